// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= lsuTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) common/lsu_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/lsuChecker.sv ====
//////////////////////////////////////////////////
// Shadow memory model and port comparison
// Assumes StallW low; misaligned loads skip data
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module lsuChecker (
  input  logic               clk, rst, StallM, FlushM, FlushW, BigEndianM,
  input  lsuPkg::wordT       IEUAdrE, WriteDataM, IEUAdrM, ReadDataW,
  input  lsuPkg::memRwT      MemRWM,
  input  lsuPkg::accessSizeT Funct3M,
  input  logic               LSUStallM, LoadMisalignedFaultM, StoreAmoMisalignedFaultM,
  output int                 errCount, checkCount
);

  lsuPkg::wordT shadow [`LSU_DTIM_WORDS];               // Expected DTIM contents
  lsuPkg::wordT adrM, loadExp;                           // Modeled M address, pending load
  logic         loadPending;

  function automatic logic isMisaligned(input logic [1:0] size, input logic [1:0] off);
    return (size == 2'b01) ? off[0] : (size == 2'b10) ? (off != 2'b00) : 1'b0;
  endfunction

  // Bytes in address order, then pick and extend
  function automatic lsuPkg::wordT refLoad(input lsuPkg::wordT memWord, input logic [1:0] off,
                                           input lsuPkg::accessSizeT f3, input logic be);
    logic [7:0] b [4];
    for (int i = 0; i < 4; i++) b[i] = memWord[8*(be ? 3-i : i) +: 8];
    case (f3)
      lsuPkg::sizeByte:  return {{24{b[off][7]}}, b[off]};
      lsuPkg::sizeByteU: return {24'h0, b[off]};
      lsuPkg::sizeHalf:  return {{16{b[{off[1], 1'b1}][7]}}, b[{off[1], 1'b1}], b[{off[1], 1'b0}]};
      lsuPkg::sizeHalfU: return {16'h0, b[{off[1], 1'b1}], b[{off[1], 1'b0}]};
      default:           return {b[3], b[2], b[1], b[0]};
    endcase
  endfunction

  task automatic storeShadow(input lsuPkg::wordT adr, input logic [1:0] size,
                             input lsuPkg::wordT data, input logic be);
    int nBytes;
    int lane;
    nBytes = (size == 2'b00) ? 1 : (size == 2'b01) ? 2 : 4;
    for (int i = 0; i < nBytes; i++) begin
      lane = (nBytes == 4) ? i : int'(adr[1:0]) + i;     // Little-endian lane
      if (be) lane = 3 - lane;                           // Mirrored for big-endian
      shadow[adr[`LSU_DTIM_ADR_BITS+1:2]][8*lane +: 8] = data[8*i +: 8];
    end
  endtask

  task automatic checkValue(input string name, input lsuPkg::wordT got, input lsuPkg::wordT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin : compareStages
    logic mis;
    if (rst) begin
      adrM        <= '0;
      loadPending <= 1'b0;
      errCount    = 0;
      checkCount  = 0;
    end else begin
      mis = isMisaligned(Funct3M[1:0], adrM[1:0]);
      checkValue("IEUAdrM", IEUAdrM, adrM);
      checkValue("LSUStallM", 32'(LSUStallM), 32'(FlushM));  // FlushM marks a predicted conflict
      checkValue("LoadMisalignedFaultM", 32'(LoadMisalignedFaultM),
                 32'((MemRWM == lsuPkg::memRead) && mis));
      checkValue("StoreAmoMisalignedFaultM", 32'(StoreAmoMisalignedFaultM),
                 32'((MemRWM == lsuPkg::memWrite) && mis));
      if (loadPending) checkValue("ReadDataW", ReadDataW, loadExp);
      loadPending <= (MemRWM == lsuPkg::memRead) && !mis;
      loadExp     <= refLoad(shadow[adrM[`LSU_DTIM_ADR_BITS+1:2]], adrM[1:0], Funct3M, BigEndianM);
      if ((MemRWM == lsuPkg::memWrite) && !mis && !FlushW) begin
        storeShadow(adrM, Funct3M[1:0], WriteDataM, BigEndianM);
      end
      if (FlushM) adrM <= '0;
      else if (!StallM) adrM <= IEUAdrE;
    end
  end

endmodule

`default_nettype wire

// ==== bench/lsuTb.sv ====
//////////////////////////////////////////////////
// Pipeline-style random stimulus for the LSU
// First 8 accesses fill an 8-word DTIM window
// StallM, StallW and FlushW stay low
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsuTb;

  localparam int NumOps      = 400;                      // Window fill plus random mix
  localparam int ResetCycles = 5;
  localparam int ClkPeriod   = 8;

  logic               clk, rst, StallM, FlushM, StallW, FlushW, BigEndianM;
  lsuPkg::wordT       IEUAdrE, WriteDataM, IEUAdrM, ReadDataW;
  lsuPkg::memRwT      MemRWE, MemRWM;
  lsuPkg::accessSizeT Funct3M, funct3E;                  // funct3E rides along with E
  lsuPkg::wordT       dataE;                             // Store data waiting in E
  logic               bigEndianE, running;
  logic               LSUStallM, LoadMisalignedFaultM, StoreAmoMisalignedFaultM;
  int                 seed, issued, errCount, checkCount;

  lsu u_lsu (.*);

  lsuChecker u_lsuChecker (.*);

  always #(ClkPeriod/2) clk = ~clk;

  // Random access inside the window, biased towards aligned addresses
  task automatic pickAccess(input int n, output lsuPkg::memRwT rw, output lsuPkg::wordT adr,
                            output lsuPkg::accessSizeT f3, output lsuPkg::wordT data,
                            output logic be);
    int r;
    r    = $random(seed);
    adr  = $random(seed);
    data = $random(seed);
    adr[9:5] = 5'b01010;                                 // Window base, upper bits random
    be   = r[16];
    case (r[2:0])
      3'd0, 3'd1, 3'd2, 3'd3: rw = lsuPkg::memRead;
      3'd4, 3'd5, 3'd6:       rw = lsuPkg::memWrite;
      default:                rw = lsuPkg::memNone;
    endcase
    case (r[10:8])
      3'd0, 3'd5: f3 = lsuPkg::sizeByte;
      3'd1, 3'd6: f3 = lsuPkg::sizeHalf;
      3'd2, 3'd7: f3 = lsuPkg::sizeWord;
      3'd3:       f3 = lsuPkg::sizeByteU;
      default:    f3 = lsuPkg::sizeHalfU;
    endcase
    if (rw == lsuPkg::memWrite) f3 = lsuPkg::accessSizeT'({1'b0, f3[1:0]});  // sb/sh/sw
    if (r[13:12] != 2'b00) begin
      if (f3[1:0] == 2'b01) adr[0] = 1'b0;
      if (f3[1:0] == 2'b10) adr[1:0] = 2'b00;
    end
    if (n < 8) begin                                     // Known contents before loads
      rw  = lsuPkg::memWrite;
      f3  = lsuPkg::sizeWord;
      be  = 1'b0;
      adr[4:0] = {n[2:0], 2'b00};
    end
  endtask

  //////////////////////////////////////////////////
  // E and M stage drive with the hazard rule
  //////////////////////////////////////////////////

  always @(posedge clk) begin : driveStages
    lsuPkg::memRwT      rw;
    lsuPkg::wordT       adr, data;
    lsuPkg::accessSizeT f3;
    logic               be;
    if (running && LSUStallM) begin
      MemRWM <= lsuPkg::memNone;                         // Flushed slot, E held
      FlushM <= 1'b0;
    end else if (running) begin
      MemRWM     <= MemRWE;                              // E access moves to M
      Funct3M    <= funct3E;
      WriteDataM <= dataE;
      BigEndianM <= bigEndianE;
      rw   = lsuPkg::memNone;
      adr  = '0;
      data = '0;
      f3   = lsuPkg::sizeWord;
      be   = 1'b0;
      if (issued < NumOps) begin
        pickAccess(issued, rw, adr, f3, data, be);
        issued <= issued + 1;
      end
      IEUAdrE    <= adr;
      MemRWE     <= rw;
      funct3E    <= f3;
      dataE      <= data;
      bigEndianE <= be;
      FlushM     <= (MemRWE == lsuPkg::memWrite) && (rw == lsuPkg::memRead);  // Predicted stall
    end
  end

  initial begin
    seed = 32'hf9f9;
    {clk, rst, StallM, FlushM, StallW, FlushW, BigEndianM} = 7'b0100000;
    {IEUAdrE, WriteDataM, dataE} = '0;
    MemRWE     = lsuPkg::memNone;
    MemRWM     = lsuPkg::memNone;
    Funct3M    = lsuPkg::sizeWord;
    funct3E    = lsuPkg::sizeWord;
    bigEndianE = 1'b0;
    running    = 1'b0;
    issued     = 0;
    repeat (ResetCycles) @(posedge clk);
    rst     <= 1'b0;
    running <= 1'b1;
    wait (issued == NumOps);
    repeat (5) @(posedge clk);                           // Stall, M, W and compare edges
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0 && checkCount > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((NumOps * 4 + ResetCycles) * ClkPeriod);
    $display("Watchdog expired before all accesses drained from the pipeline");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/lsuPkg.sv ====
//////////////////////////////////////////////////
// Shared types for the load/store unit
// memRwT encoding matches the pipeline MemRW field
// accessSizeT is funct3 of the load/store opcode
//////////////////////////////////////////////////

`default_nettype none

`include "lsu_macros.svh"

package lsuPkg;

  // Data or address word
  typedef logic [`LSU_XLEN-1:0] wordT;

  // One write enable per byte lane
  typedef logic [`LSU_XLEN/8-1:0] byteMaskT;

  // Memory operation in a stage
  typedef enum logic [1:0] {
    memNone  = 2'b00,                            // No access
    memWrite = 2'b01,                            // Store
    memRead  = 2'b10                             // Load
  } memRwT;

  // Access size and sign, straight from funct3
  typedef enum logic [2:0] {
    sizeByte  = 3'd0,                            // lb / sb
    sizeHalf  = 3'd1,                            // lh / sh
    sizeWord  = 3'd2,                            // lw / sw
    sizeByteU = 3'd4,                            // lbu
    sizeHalfU = 3'd5                             // lhu
  } accessSizeT;

endpackage

`default_nettype wire

// ==== common/lsu_macros.svh ====
//////////////////////////////////////////////////
// Width and DTIM sizing for the load/store unit
// Width is fixed at 32 bits, addresses are physical
// DTIM depth must equal 2**LSU_DTIM_ADR_BITS
//////////////////////////////////////////////////

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data and address width
`define LSU_XLEN 32

// Number of 32-bit words in the DTIM
`define LSU_DTIM_WORDS 256

// Word index width into the DTIM
`define LSU_DTIM_ADR_BITS 8

`endif

// ==== dtim/dtim.sv ====
//////////////////////////////////////////////////
// Byte-writable synchronous DTIM
// Word addressed, upper address bits ignored
// Read and write share one port, so a store in M
// blocks the read of a load in E for a cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module dtim (
  input  logic             clk,                          // Core clock
  input  logic             StallW,                       // Freeze memory and output
  input  lsuPkg::wordT     IEUAdrE,                      // Read address
  input  lsuPkg::wordT     IEUAdrM,                      // Write address
  input  lsuPkg::memRwT    MemRWE,                       // Operation in E
  input  lsuPkg::memRwT    MemRWM,                       // Operation in M
  input  logic             StoreEnM,                     // Aligned, unflushed store
  input  lsuPkg::byteMaskT ByteMaskM,                    // Lane write enables
  input  lsuPkg::wordT     StoreDataM,                   // Lane-aligned store data
  output lsuPkg::wordT     ReadDataWordM,                // Registered read word
  output logic             LSUStallM                     // Port conflict
);

  lsuPkg::wordT                  mem [`LSU_DTIM_WORDS];  // Storage array
  logic [`LSU_DTIM_ADR_BITS-1:0] memIdx;                 // Selected word index
  logic                          writeM;                 // Store owns the port

  assign writeM = (MemRWM == lsuPkg::memWrite);

  //////////////////////////////////////////////////
  // Address select
  //////////////////////////////////////////////////

  // Stores use the M address, everything else reads ahead from E
  assign memIdx = writeM ? IEUAdrM[`LSU_DTIM_ADR_BITS+1:2]
                         : IEUAdrE[`LSU_DTIM_ADR_BITS+1:2];

  //////////////////////////////////////////////////
  // Memory port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!StallW) begin
      if (writeM) begin
        for (int i = 0; i < `LSU_XLEN/8; i++) begin
          if (StoreEnM && ByteMaskM[i]) begin
            mem[memIdx][8*i +: 8] <= StoreDataM[8*i +: 8];  // Enabled lanes only
          end
        end
      end else begin
        ReadDataWordM <= mem[memIdx];                    // Output held while writing
      end
    end
  end

  // Load in E must wait for the store in M
  assign LSUStallM = writeM && (MemRWE == lsuPkg::memRead);

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/lsuPkg.sv
src/storeFormat.sv
dtim/dtim.sv
src/loadFormat.sv
src/lsu.sv
bench/lsuChecker.sv
bench/lsuTb.sv

// ==== src/loadFormat.sv ====
//////////////////////////////////////////////////
// Load formatting and M to W read data register
// Swap happens before lane select, matching the
// mirrored store path
// Misaligned loads still return data; the fault
// output is what stops the pipeline using it
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lsu_macros.svh"

module loadFormat (
  input  logic               clk,                       // Core clock
  input  logic               StallW,                    // Hold the W register
  input  lsuPkg::wordT       ReadDataWordM,             // Raw DTIM word
  input  lsuPkg::wordT       IEUAdrM,                   // Memory stage address
  input  lsuPkg::accessSizeT Funct3M,                   // Size and sign of access
  input  logic               BigEndianM,                // Big-endian data access
  output lsuPkg::wordT       ReadDataW                  // Load result to writeback
);

  lsuPkg::wordT leWordM;                                 // Word in little-endian order
  logic [7:0]   byteM;                                   // Addressed byte
  logic [15:0]  halfM;                                   // Addressed halfword
  lsuPkg::wordT ReadDataM;                               // Extended result

  //////////////////////////////////////////////////
  // Endian swap and lane select
  //////////////////////////////////////////////////

  assign leWordM = BigEndianM ? {<<8{ReadDataWordM}} : ReadDataWordM;

  assign byteM = leWordM[{IEUAdrM[1:0], 3'b000} +: 8];   // Byte at offset
  assign halfM = IEUAdrM[1] ? leWordM[31:16]             // Upper half
                            : leWordM[15:0];             // Lower half

  //////////////////////////////////////////////////
  // Sign or zero extension
  //////////////////////////////////////////////////

  always_comb begin
    case (Funct3M)
      lsuPkg::sizeByte:  ReadDataM = {{(`LSU_XLEN-8){byteM[7]}}, byteM};
      lsuPkg::sizeHalf:  ReadDataM = {{(`LSU_XLEN-16){halfM[15]}}, halfM};
      lsuPkg::sizeByteU: ReadDataM = {{(`LSU_XLEN-8){1'b0}}, byteM};
      lsuPkg::sizeHalfU: ReadDataM = {{(`LSU_XLEN-16){1'b0}}, halfM};
      default:           ReadDataM = leWordM;             // Word or unused funct3
    endcase
  end

  //////////////////////////////////////////////////
  // M to W register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!StallW) begin
      ReadDataW <= ReadDataM;                            // Formatted load to writeback
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
//////////////////////////////////////////////////
// Load/store unit serving only the DTIM
// No translation, no cache, no bus, no atomics
// Stall and flush inputs are plain levels from
// the hazard unit; LSUStallM is combinational
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu (
  input  logic               clk,                       // Core clock
  input  logic               rst,                       // Synchronous reset
  input  logic               StallM,                    // Hold the M stage
  input  logic               FlushM,                    // Bubble into the M stage
  input  logic               StallW,                    // Hold the W stage
  input  logic               FlushW,                    // Kill the access in M
  input  lsuPkg::wordT       IEUAdrE,                   // Execute stage address
  input  lsuPkg::memRwT      MemRWE,                    // Execute stage read/write
  input  lsuPkg::memRwT      MemRWM,                    // Memory stage read/write
  input  lsuPkg::accessSizeT Funct3M,                   // Size and sign of access
  input  lsuPkg::wordT       WriteDataM,                // Store data from IEU
  input  logic               BigEndianM,                // Big-endian data access
  output lsuPkg::wordT       IEUAdrM,                   // Memory stage address
  output lsuPkg::wordT       ReadDataW,                 // Load result to writeback
  output logic               LSUStallM,                 // Store/load conflict stall
  output logic               LoadMisalignedFaultM,      // Misaligned load
  output logic               StoreAmoMisalignedFaultM   // Misaligned store
);

  lsuPkg::byteMaskT ByteMaskM;                           // Lane enables for the store
  lsuPkg::wordT     StoreDataM;                          // Lane-aligned store data
  logic             StoreEnM;                            // Store commits this cycle
  lsuPkg::wordT     ReadDataWordM;                       // Raw DTIM word

  //////////////////////////////////////////////////
  // Store side, E to M address and faults
  //////////////////////////////////////////////////

  storeFormat u_storeFormat (
    .clk, .rst, .StallM, .FlushM, .FlushW,
    .IEUAdrE, .MemRWM, .Funct3M, .WriteDataM, .BigEndianM,
    .IEUAdrM, .ByteMaskM, .StoreDataM, .StoreEnM,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM
  );

  //////////////////////////////////////////////////
  // Data memory
  //////////////////////////////////////////////////

  dtim u_dtim (
    .clk, .StallW,
    .IEUAdrE, .IEUAdrM, .MemRWE, .MemRWM,
    .StoreEnM, .ByteMaskM, .StoreDataM,
    .ReadDataWordM, .LSUStallM
  );

  //////////////////////////////////////////////////
  // Load side and M to W register
  //////////////////////////////////////////////////

  loadFormat u_loadFormat (
    .clk, .StallW,
    .ReadDataWordM, .IEUAdrM, .Funct3M, .BigEndianM,
    .ReadDataW
  );

endmodule

`default_nettype wire

// ==== src/storeFormat.sv ====
//////////////////////////////////////////////////
// E to M address register and store formatting
// Misaligned halfword/word accesses fault, never spill
// Big-endian mirrors both the mask and the data
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module storeFormat (
  input  logic               clk,                       // Core clock
  input  logic               rst,                       // Synchronous reset
  input  logic               StallM,                    // Hold the address register
  input  logic               FlushM,                    // Clear the address register
  input  logic               FlushW,                    // Suppress the write
  input  lsuPkg::wordT       IEUAdrE,                   // Execute stage address
  input  lsuPkg::memRwT      MemRWM,                    // Memory stage read/write
  input  lsuPkg::accessSizeT Funct3M,                   // Size and sign of access
  input  lsuPkg::wordT       WriteDataM,                // Store data from IEU
  input  logic               BigEndianM,                // Big-endian data access
  output lsuPkg::wordT       IEUAdrM,                   // Memory stage address
  output lsuPkg::byteMaskT   ByteMaskM,                 // Lane write enables
  output lsuPkg::wordT       StoreDataM,                // Lane-aligned store data
  output logic               StoreEnM,                  // Store commits
  output logic               LoadMisalignedFaultM,      // Misaligned load
  output logic               StoreAmoMisalignedFaultM   // Misaligned store
);

  logic             misalignedM;                         // Size and offset disagree
  lsuPkg::byteMaskT leMaskM;                             // Mask in little-endian order
  lsuPkg::wordT     leDataM;                             // Replicated data, little-endian

  //////////////////////////////////////////////////
  // Address register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || FlushM) begin
      IEUAdrM <= '0;                                     // Bubble carries address zero
    end else if (!StallM) begin
      IEUAdrM <= IEUAdrE;
    end
  end

  //////////////////////////////////////////////////
  // Alignment check
  //////////////////////////////////////////////////

  always_comb begin
    unique case (Funct3M[1:0])
      2'b01:   misalignedM = IEUAdrM[0];                 // Halfword on odd byte
      2'b10:   misalignedM = |IEUAdrM[1:0];              // Word off a word boundary
      default: misalignedM = 1'b0;                       // Bytes are always aligned
    endcase
  end

  assign LoadMisalignedFaultM     = (MemRWM == lsuPkg::memRead) && misalignedM;
  assign StoreAmoMisalignedFaultM = (MemRWM == lsuPkg::memWrite) && misalignedM;

  // Faulting or flushed stores never reach the DTIM
  assign StoreEnM = (MemRWM == lsuPkg::memWrite) && !misalignedM && !FlushW;

  //////////////////////////////////////////////////
  // Byte mask and lane replication
  //////////////////////////////////////////////////

  always_comb begin
    unique case (Funct3M[1:0])
      2'b00: begin
        leMaskM = 4'b0001 << IEUAdrM[1:0];              // One lane at the offset
        leDataM = {4{WriteDataM[7:0]}};                 // Byte in every lane
      end
      2'b01: begin
        leMaskM = 4'b0011 << {IEUAdrM[1], 1'b0};        // Low or high half
        leDataM = {2{WriteDataM[15:0]}};                // Half in both halves
      end
      default: begin
        leMaskM = 4'b1111;                               // Whole word
        leDataM = WriteDataM;
      end
    endcase
  end

  // Mirror lanes for big-endian memory
  assign ByteMaskM  = BigEndianM ? {<<{leMaskM}} : leMaskM;
  assign StoreDataM = BigEndianM ? {<<8{leDataM}} : leDataM;

endmodule

`default_nettype wire
